/* verilog/rab_pkg.sv */
package rab_pkg;

  // ------------------------------
  // wishbone side
  // ------------------------------

  // word address width of the slave port
  localparam int WB_ADDR_W = 4;

  // push register, writes go straight into the fifo
  localparam logic [WB_ADDR_W-1:0] ADDR_DATA = 4'd0;

  // fill level readback, read only
  localparam logic [WB_ADDR_W-1:0] ADDR_STATUS = 4'd1;

  // ------------------------------
  // default sizes
  // ------------------------------

  // payload word width
  localparam int DATA_W_DEF = 32;

  // fifo depth, power of two
  localparam int DEPTH_DEF = 8;

endpackage

/* verilog/fifo_wr_if.sv */
`timescale 1ns/100ps

interface fifo_wr_if #(
  parameter int DATA_W = rab_pkg::DATA_W_DEF,
  parameter int DEPTH  = rab_pkg::DEPTH_DEF
);

  // one extra bit so a full fifo fits
  localparam int LVL_W = $clog2(DEPTH) + 1;

  // push strobe, word is stored on the same edge
  logic              wr_req;
  logic [DATA_W-1:0] wr_data;

  // status back from the fifo
  logic              full;
  logic [LVL_W-1:0]  level;

  // wishbone writer side
  modport writer (output wr_req, output wr_data, input full, input level);

  // fifo side
  modport fifo (input wr_req, input wr_data, output full, output level);

endinterface

/* verilog/wb_fifo_writer.sv */
`timescale 1ns/100ps

module wb_fifo_writer #(
  parameter int DATA_W = rab_pkg::DATA_W_DEF,
  parameter int DEPTH  = rab_pkg::DEPTH_DEF
) (
  input  logic                         clk,
  input  logic                         anrst,
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  logic                         wb_we,
  input  logic [rab_pkg::WB_ADDR_W-1:0] wb_adr,
  input  logic [DATA_W-1:0]            wb_dat_w,
  output logic [DATA_W-1:0]            wb_dat_r,
  output logic                         wb_ack,
  fifo_wr_if.writer                    wr
);

  import rab_pkg::*;

  localparam int LVL_W = $clog2(DEPTH) + 1;

  logic              req_active;
  logic              is_data;
  logic              is_status;
  logic              ack_d;
  logic [DATA_W-1:0] dat_r_d;

  // ------------------------------
  // decode
  // ------------------------------

  // no new request in the ack cycle, keeps acks one cycle apart
  assign req_active = wb_cyc && wb_stb && !wb_ack;
  assign is_data    = (wb_adr == ADDR_DATA);
  assign is_status  = (wb_adr == ADDR_STATUS);

  // push goes out with the request, ack follows a cycle later
  assign wr.wr_req  = req_active && wb_we && is_data && !wr.full;
  assign wr.wr_data = wb_dat_w;

  always_comb begin
    ack_d   = req_active;
    dat_r_d = '0;
    // full fifo stalls a data write until space opens
    if (wb_we && is_data && wr.full) begin
      ack_d = 1'b0;
    end
    // level readback, zero extended
    if (!wb_we && is_status) begin
      dat_r_d = {{(DATA_W-LVL_W){1'b0}}, wr.level};
    end
  end

  // ------------------------------
  // registered response
  // ------------------------------

  always_ff @(posedge clk or negedge anrst) begin
    if (!anrst) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= ack_d;
    end
  end

  // read data goes out alongside ack
  always_ff @(posedge clk) begin
    if (ack_d) begin
      wb_dat_r <= dat_r_d;
    end
  end

  // master holds the cycle until it sees ack
  ack_in_cycle_a: assert property (@(posedge clk) disable iff (!anrst)
    wb_ack |-> (wb_cyc && wb_stb));

endmodule

/* verilog/fwft_fifo.sv */
`timescale 1ns/100ps

module fwft_fifo #(
  parameter int DATA_W = rab_pkg::DATA_W_DEF,
  parameter int DEPTH  = rab_pkg::DEPTH_DEF
) (
  input  logic              clk,
  input  logic              anrst,
  // read side, first word falls through
  input  logic              fifo_r_req,
  output logic [DATA_W-1:0] fifo_r_data,
  output logic              fifo_empty,
  // write side
  fifo_wr_if.fifo           wr
);

  // pointers wrap on their own, depth is a power of two
  localparam int PTR_W = $clog2(DEPTH);
  localparam int LVL_W = PTR_W + 1;

  logic [DATA_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [LVL_W-1:0]  level;
  logic              push;
  logic              pop;

  // ------------------------------
  // flags
  // ------------------------------

  assign wr.full    = (level == LVL_W'(DEPTH));
  assign fifo_empty = (level == '0);
  assign wr.level   = level;

  // guarded so a stray strobe cannot corrupt pointers
  assign push = wr.wr_req && !wr.full;
  assign pop  = fifo_r_req && !fifo_empty;

  // ------------------------------
  // storage
  // ------------------------------

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr.wr_data;
    end
  end

  // head word, visible whenever not empty
  assign fifo_r_data = mem[rd_ptr];

  // ------------------------------
  // pointers and level
  // ------------------------------

  always_ff @(posedge clk or negedge anrst) begin
    if (!anrst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // level only moves when exactly one side acts
  always_ff @(posedge clk or negedge anrst) begin
    if (!anrst) begin
      level <= '0;
    end else begin
      case ({push, pop})
        2'b10: begin
          level <= level + 1'b1;
        end
        2'b01: begin
          level <= level - 1'b1;
        end
        default: begin
          level <= level;
        end
      endcase
    end
  end

  // read-ahead buffer only pops a non-empty fifo
  no_pop_empty_a: assert property (@(posedge clk) disable iff (!anrst)
    fifo_r_req |-> !fifo_empty);

  // wishbone writer respects back-pressure
  no_push_full_a: assert property (@(posedge clk) disable iff (!anrst)
    wr.wr_req |-> !wr.full);

endmodule

/* verilog/read_ahead_buf.sv */
`timescale 1ns/100ps

module read_ahead_buf #(
  parameter int DATA_W = rab_pkg::DATA_W_DEF
) (
  input  logic              clk,
  input  logic              anrst,
  // fifo read port
  output logic              fifo_r_req,
  input  logic [DATA_W-1:0] fifo_r_data,
  input  logic              fifo_empty,
  // consumer read port
  input  logic              rd_req,
  output logic [DATA_W-1:0] rd_data,
  output logic              rd_empty
);

  logic              fifo_empty_d;
  logic              fifo_empty_fall;
  logic              buf_empty;
  logic              phantom_read;
  logic              normal_read;
  logic              depletion;
  logic [DATA_W-1:0] buf_data;

  // ------------------------------
  // fifo empty edge detect
  // ------------------------------

  // starts high, fifo is empty out of reset
  always_ff @(posedge clk or negedge anrst) begin
    if (!anrst) begin
      fifo_empty_d <= 1'b1;
    end else begin
      fifo_empty_d <= fifo_empty;
    end
  end

  assign fifo_empty_fall = fifo_empty_d && !fifo_empty;

  // ------------------------------
  // read decisions
  // ------------------------------

  // first word after an empty spell moves into the buffer unasked
  assign phantom_read = fifo_empty_fall && buf_empty;

  // refill buffer behind each consumer read
  assign normal_read = rd_req && !fifo_empty;

  // last buffered word leaves, nothing behind it
  assign depletion = rd_req && fifo_empty;

  assign fifo_r_req = phantom_read || normal_read;

  // early empty when the request takes the last word
  assign rd_empty = buf_empty || depletion;

  // buffer occupancy flag
  always_ff @(posedge clk or negedge anrst) begin
    if (!anrst) begin
      buf_empty <= 1'b1;
    end else if (phantom_read) begin
      buf_empty <= 1'b0;
    end else if (depletion) begin
      buf_empty <= 1'b1;
    end
  end

  // ------------------------------
  // data path
  // ------------------------------

  // buffered word, loaded on every pop
  always_ff @(posedge clk) begin
    if (fifo_r_req) begin
      buf_data <= fifo_r_data;
    end
  end

  // output holding register
  // normal read or depletion both hand the buffered word out
  always_ff @(posedge clk or negedge anrst) begin
    if (!anrst) begin
      rd_data <= '0;
    end else if (normal_read || depletion) begin
      rd_data <= buf_data;
    end
  end

  // consumer only reads while a word sits in the buffer
  rd_when_ready_a: assert property (@(posedge clk) disable iff (!anrst)
    rd_req |-> !buf_empty);

endmodule

/* verilog/rab_stream_top.sv */
`timescale 1ns/100ps

module rab_stream_top #(
  parameter int DATA_W = rab_pkg::DATA_W_DEF,
  parameter int DEPTH  = rab_pkg::DEPTH_DEF
) (
  input  logic                         clk,
  input  logic                         anrst,
  // wishbone classic slave
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  logic                         wb_we,
  input  logic [rab_pkg::WB_ADDR_W-1:0] wb_adr,
  input  logic [DATA_W-1:0]            wb_dat_w,
  output logic [DATA_W-1:0]            wb_dat_r,
  output logic                         wb_ack,
  // consumer read port
  input  logic                         rd_req,
  output logic [DATA_W-1:0]            rd_data,
  output logic                         rd_empty
);

  // fifo to read-ahead buffer
  logic              fifo_r_req;
  logic [DATA_W-1:0] fifo_r_data;
  logic              fifo_empty;

  // writer to fifo
  fifo_wr_if #(.DATA_W(DATA_W), .DEPTH(DEPTH)) wr_if ();

  // ------------------------------
  // wishbone push side
  // ------------------------------

  wb_fifo_writer #(.DATA_W(DATA_W), .DEPTH(DEPTH)) writer_i (
    .clk      (clk),
    .anrst    (anrst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .wr       (wr_if.writer)
  );

  // ------------------------------
  // storage and read side
  // ------------------------------

  fwft_fifo #(.DATA_W(DATA_W), .DEPTH(DEPTH)) fifo_i (
    .clk         (clk),
    .anrst       (anrst),
    .fifo_r_req  (fifo_r_req),
    .fifo_r_data (fifo_r_data),
    .fifo_empty  (fifo_empty),
    .wr          (wr_if.fifo)
  );

  read_ahead_buf #(.DATA_W(DATA_W)) rab_i (
    .clk         (clk),
    .anrst       (anrst),
    .fifo_r_req  (fifo_r_req),
    .fifo_r_data (fifo_r_data),
    .fifo_empty  (fifo_empty),
    .rd_req      (rd_req),
    .rd_data     (rd_data),
    .rd_empty    (rd_empty)
  );

endmodule

/* tb/rab_tb_model.svh */
`ifndef RAB_TB_MODEL_SVH
`define RAB_TB_MODEL_SVH

// ------------------------------
// reference model
// ------------------------------

// words acked on the data address, oldest first
logic [DATA_W-1:0] exp_q [$];

// every acked push lands at the tail
function automatic void record_write(input logic [DATA_W-1:0] word);
  exp_q.push_back(word);
endfunction

// next word the consumer should see
function automatic logic [DATA_W-1:0] next_read_word();
  return exp_q[0];
endfunction

// head leaves once the consumer has taken it
function automatic logic [DATA_W-1:0] pop_expected();
  logic [DATA_W-1:0] word;
  word = next_read_word();
  exp_q.delete(0);
  return word;
endfunction

// fifo words plus the read-ahead slot
function automatic int stream_capacity();
  return DEPTH + 1;
endfunction

// buffered word sits outside the fifo count
function automatic int quiescent_level();
  int lvl;
  if (exp_q.size() == 0) begin
    lvl = 0;
  end else begin
    lvl = exp_q.size() - 1;
  end
  return lvl;
endfunction

`endif

/* tb/rab_tb.sv */
`timescale 1ns/100ps

module rab_tb;

  import rab_pkg::*;

  localparam int DATA_W    = DATA_W_DEF;
  localparam int DEPTH     = DEPTH_DEF;
  localparam int SOAK_TXNS = 400;
  // fixed budget plus a share per random transaction
  localparam int WATCHDOG_CYCLES = 2000 + 40 * SOAK_TXNS;
  // generous bound on a single wishbone cycle
  localparam int ACK_WAIT = 200;

  logic                 clk;
  logic                 anrst;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  logic [WB_ADDR_W-1:0] wb_adr;
  logic [DATA_W-1:0]    wb_dat_w;
  logic [DATA_W-1:0]    wb_dat_r;
  logic                 wb_ack;
  logic                 rd_req;
  logic [DATA_W-1:0]    rd_data;
  logic                 rd_empty;
  logic                 soak_done;

  `include "rab_tb_model.svh"

  rab_stream_top #(.DATA_W(DATA_W), .DEPTH(DEPTH)) dut_i (
    .clk      (clk),
    .anrst    (anrst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .rd_req   (rd_req),
    .rd_data  (rd_data),
    .rd_empty (rd_empty)
  );

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // ------------------------------
  // reporting
  // ------------------------------

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_eq(input string name, input logic [63:0] got,
                          input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%0h, expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  // ------------------------------
  // bus and read helpers
  // ------------------------------

  // all helpers start and end on a falling edge
  task automatic start_cycle(input logic we, input logic [WB_ADDR_W-1:0] adr,
                             input logic [DATA_W-1:0] word);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = word;
  endtask

  task automatic wait_ack(input int max_cycles, output logic got_ack,
                          output logic [DATA_W-1:0] data);
    int n;
    got_ack = 1'b0;
    data    = '0;
    n       = 0;
    while (!got_ack && n < max_cycles) begin
      @(negedge clk);
      n++;
      if (wb_ack) begin
        got_ack = 1'b1;
        data    = wb_dat_r;
      end
    end
    if (got_ack) begin
      // ack is sampled on the next rising edge, release after it
      @(negedge clk);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
    end
  endtask

  task automatic wb_write(input logic [WB_ADDR_W-1:0] adr, input logic [DATA_W-1:0] word);
    logic              ok;
    logic [DATA_W-1:0] unused;
    start_cycle(1'b1, adr, word);
    wait_ack(ACK_WAIT, ok, unused);
    if (!ok) begin
      $display("write to address 0x%0h was never acknowledged", adr);
      abort_run();
    end
    // only the push register feeds the stream
    if (adr == ADDR_DATA) begin
      record_write(word);
    end
  endtask

  task automatic wb_read(input logic [WB_ADDR_W-1:0] adr, output logic [DATA_W-1:0] data);
    logic ok;
    start_cycle(1'b0, adr, '0);
    wait_ack(ACK_WAIT, ok, data);
    if (!ok) begin
      $display("read of address 0x%0h was never acknowledged", adr);
      abort_run();
    end
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) @(negedge clk);
  endtask

  // one-cycle request, only while a word is offered
  task automatic read_one();
    if (!rd_empty) begin
      rd_req = 1'b1;
    end
    @(negedge clk);
    rd_req = 1'b0;
  endtask

  // read until the model runs dry, give up after a long quiet spell
  task automatic drain_all();
    int quiet;
    quiet = 0;
    while (exp_q.size() != 0 && quiet < 20) begin
      if (rd_empty) begin
        quiet++;
      end else begin
        quiet = 0;
      end
      read_one();
    end
    check_eq("model queue size", 64'(exp_q.size()), 64'd0);
    // nothing left behind in the stream either
    idle(4);
    check_eq("rd_empty", 64'(rd_empty), 64'd1);
  endtask

  // ------------------------------
  // compare process
  // ------------------------------

  // word shows up the cycle after its request
  initial begin : compare_reads
    logic [DATA_W-1:0] exp_word;
    forever begin
      @(posedge clk);
      if (anrst && rd_req) begin
        @(negedge clk);
        if (exp_q.size() == 0) begin
          $display("consumer read a word that was never written");
          abort_run();
        end
        exp_word = pop_expected();
        check_eq("rd_data", 64'(rd_data), 64'(exp_word));
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("run timed out after %0d clock cycles", WATCHDOG_CYCLES);
    abort_run();
  end

  // ------------------------------
  // stimulus
  // ------------------------------

  initial begin : stimulus
    logic [DATA_W-1:0] word;
    logic [DATA_W-1:0] ack_data;
    logic              ok;
    int                n;
    int                targets [3];
    void'($urandom(12992));
    anrst     = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    rd_req    = 1'b0;
    soak_done = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    anrst = 1'b1;
    @(negedge clk);

    // reset state, empty status
    check_eq("rd_empty", 64'(rd_empty), 64'd1);
    check_eq("wb_ack", 64'(wb_ack), 64'd0);
    check_eq("rd_data", 64'(rd_data), 64'd0);
    wb_read(ADDR_STATUS, word);
    check_eq("wb_dat_r status", 64'(word), 64'd0);

    // level readback at 1, 5 and full stream
    targets = '{1, 5, DEPTH + 1};
    foreach (targets[i]) begin
      while (exp_q.size() < targets[i]) begin
        word = $urandom();
        wb_write(ADDR_DATA, word);
      end
      idle(4);
      wb_read(ADDR_STATUS, word);
      check_eq("wb_dat_r status", 64'(word), 64'(quiescent_level()));
    end
    drain_all();

    // ordered delivery in bursts, never past capacity
    for (int b = 0; b < 12; b++) begin
      n = $urandom_range(1, 6);
      for (int i = 0; i < n && exp_q.size() < stream_capacity(); i++) begin
        word = $urandom();
        wb_write(ADDR_DATA, word);
      end
      n = $urandom_range(0, 6);
      repeat (n) read_one();
    end
    drain_all();

    // capacity then back-pressure
    for (int i = 0; i < stream_capacity(); i++) begin
      word = $urandom();
      wb_write(ADDR_DATA, word);
    end
    idle(4);
    word = $urandom();
    start_cycle(1'b1, ADDR_DATA, word);
    wait_ack(20, ok, ack_data);
    check_eq("wb_ack while full", 64'(ok), 64'd0);
    check_eq("rd_empty", 64'(rd_empty), 64'd0);
    // one read frees a slot for the stalled write
    read_one();
    wait_ack(ACK_WAIT, ok, ack_data);
    check_eq("wb_ack after read", 64'(ok), 64'd1);
    record_write(word);
    drain_all();

    // unmapped addresses
    wb_read(WB_ADDR_W'(5), word);
    check_eq("wb_dat_r unmapped", 64'(word), 64'd0);
    wb_write(WB_ADDR_W'(7), 32'hdead_beef);
    idle(4);
    check_eq("rd_empty after unmapped write", 64'(rd_empty), 64'd1);
    wb_write(ADDR_DATA, 32'h0123_4567);
    wb_write(ADDR_DATA, 32'h89ab_cdef);
    drain_all();

    // random soak, consumer runs alongside the writer
    fork
      begin
        for (int t = 0; t < SOAK_TXNS; t++) begin
          if ($urandom_range(0, 2) != 0) begin
            word = $urandom();
            wb_write(ADDR_DATA, word);
          end else begin
            idle($urandom_range(1, 4));
          end
        end
        soak_done = 1'b1;
      end
      begin
        while (!soak_done) begin
          if ($urandom_range(0, 1) == 1) begin
            read_one();
          end else begin
            @(negedge clk);
          end
        end
      end
    join
    drain_all();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* flist.f */
+incdir+tb
verilog/rab_pkg.sv
verilog/fifo_wr_if.sv
verilog/wb_fifo_writer.sv
verilog/fwft_fifo.sv
verilog/read_ahead_buf.sv
verilog/rab_stream_top.sv
tb/rab_tb.sv

/* Makefile */
# Verilator build and run of the read-ahead stream testbench
# any variable below can be set on the command line

VERILATOR       ?= verilator
TOP             ?= rab_tb
FLIST           ?= flist.f
BUILD_DIR       ?= obj_dir
SIM_NAME        ?= V$(TOP)
SIM_BIN         ?= $(BUILD_DIR)/$(SIM_NAME)
VERILATOR_FLAGS ?= --binary --timing --assert -j 0

# rebuild only when a source or the file list changes
SOURCES := $(wildcard verilog/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(SIM_NAME) -f $(FLIST)

# exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
